// File: verilog/kernel_pkg.sv
package kernel_pkg;

    // configuration bus
    localparam int CFG_DWIDTH = 32;
    localparam int CFG_AWIDTH = 5;

    // weight stream and kernel word layout
    localparam int STR_WIDTH  = 16;
    localparam int KER_WIDTH  = 16;
    localparam int LANE_NB    = 4;
    localparam int KER_WORD   = LANE_NB * KER_WIDTH;
    localparam int BEAT_NB    = 4;

    // kernel memory
    localparam int MEM_AWIDTH = 4;
    localparam int MEM_DEPTH  = 1 << MEM_AWIDTH;

    typedef enum logic [CFG_AWIDTH-1:0] {
        CFG_KER_WR = 5'd1,
        CFG_KER_RD = 5'd2
    } cfg_addr_e;

    // one-cycle region command, where set marks the cycle it applies
    typedef struct packed {
        logic                  set;
        logic [MEM_AWIDTH-1:0] start;
        logic [MEM_AWIDTH-1:0] last;
    } region_cmd_t;

    typedef struct packed {
        logic                  req;
        logic                  we;
        logic [MEM_AWIDTH-1:0] addr;
        logic [KER_WORD-1:0]   data;
    } mem_req_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_BIAS,
        RD_KER,
        RD_HOLD
    } reader_state_e;

endpackage

// File: verilog/kernel_cfg.sv
`timescale 1ns/1ps

module kernel_cfg import kernel_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [CFG_DWIDTH-1:0] cfg_data,
    input  cfg_addr_e             cfg_addr,
    input  logic                  cfg_valid,
    output region_cmd_t           wr_cmd,
    output region_cmd_t           rd_cmd
);

    logic wr_hit;
    logic rd_hit;

    assign wr_hit = cfg_valid && (cfg_addr == CFG_KER_WR);
    assign rd_hit = cfg_valid && (cfg_addr == CFG_KER_RD);

    // set bits are strobes, the region fields keep their last value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cmd <= '0;
            rd_cmd <= '0;
        end else begin
            wr_cmd.set <= wr_hit;
            rd_cmd.set <= rd_hit;

            if (wr_hit) begin
                // the write region always begins at address 0
                wr_cmd.start <= '0;
                wr_cmd.last  <= cfg_data[0 +: MEM_AWIDTH];
            end

            if (rd_hit) begin
                rd_cmd.start <= cfg_data[0 +: MEM_AWIDTH];
                rd_cmd.last  <= cfg_data[CFG_DWIDTH/2 +: MEM_AWIDTH];
            end
        end
    end

    // the bias sits at start, so at least one kernel must follow it
    a_rd_region_order : assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_cmd.set |-> (rd_cmd.last > rd_cmd.start)
    ) else $error("read region end is not above its start");

endmodule

// File: verilog/ker_gearbox.sv
`timescale 1ns/1ps

module ker_gearbox import kernel_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [STR_WIDTH-1:0] up_data,
    input  logic                 up_val,
    output logic                 up_rdy,
    output logic [KER_WORD-1:0]  dn_data,
    output logic                 dn_val,
    input  logic                 dn_rdy
);

    logic [$clog2(BEAT_NB)-1:0] beat_cnt;
    logic                       up_xfer;
    logic                       dn_xfer;

    // a full word blocks the stream until the writer takes it
    assign up_rdy  = !dn_val;
    assign up_xfer = up_val && up_rdy;
    assign dn_xfer = dn_val && dn_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            dn_val   <= 1'b0;
        end else begin
            if (dn_xfer) begin
                dn_val <= 1'b0;
            end

            if (up_xfer) begin
                beat_cnt <= beat_cnt + 1'b1;
                // last lane filled, so the word is complete
                if (beat_cnt == BEAT_NB - 1) begin
                    dn_val <= 1'b1;
                end
            end
        end
    end

    // first beat goes to lane 0 in the low bits
    always_ff @(posedge clk) begin
        if (up_xfer) begin
            dn_data[beat_cnt*STR_WIDTH +: STR_WIDTH] <= up_data;
        end
    end

    a_dn_stable : assert property (
        @(posedge clk) disable iff (!rst_n)
        (dn_val && !dn_rdy) |=> $stable(dn_data)
    ) else $error("gearbox word changed while stalled");

endmodule

// File: verilog/ker_writer.sv
`timescale 1ns/1ps

module ker_writer import kernel_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  region_cmd_t         wr_cmd,
    input  logic [KER_WORD-1:0] word,
    input  logic                word_val,
    output logic                word_rdy,
    input  logic                grant,
    output mem_req_t            mem_req,
    output logic                loaded
);

    logic                  active;
    logic [MEM_AWIDTH-1:0] wr_addr;
    logic [MEM_AWIDTH-1:0] wr_last;

    // the word is consumed on the same edge that writes it
    assign word_rdy = grant;

    always_comb begin
        mem_req.req  = active && word_val;
        mem_req.we   = 1'b1;
        mem_req.addr = wr_addr;
        mem_req.data = word;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active  <= 1'b0;
            wr_addr <= '0;
            wr_last <= '0;
            loaded  <= 1'b0;
        end else if (wr_cmd.set) begin
            active  <= 1'b1;
            wr_addr <= wr_cmd.start;
            wr_last <= wr_cmd.last;
            loaded  <= 1'b0;
        end else if (grant) begin
            if (wr_addr == wr_last) begin
                active <= 1'b0;
                loaded <= 1'b1;
            end else begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    a_wr_in_region : assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_req.req |-> (mem_req.addr <= wr_last)
    ) else $error("write requested past the region end");

endmodule

// File: verilog/ker_reader.sv
`timescale 1ns/1ps

module ker_reader import kernel_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  region_cmd_t         rd_cmd,
    input  logic                grant,
    input  logic [KER_WORD-1:0] rd_data,
    input  logic                rd_data_val,
    input  logic                kernel_rdy,
    output mem_req_t            mem_req,
    output logic [KER_WORD-1:0] bias_bus,
    output logic [KER_WORD-1:0] kernel_bus,
    output logic                kernel_val
);

    reader_state_e         state;
    logic [MEM_AWIDTH-1:0] reg_start;
    logic [MEM_AWIDTH-1:0] reg_last;
    logic [MEM_AWIDTH-1:0] fetch_addr;
    logic                  inflight;
    logic                  seq_tag;
    logic                  ret_tag;
    logic                  ret_ok;

    assign kernel_val = (state == RD_HOLD);

    // a return is only kept if no region replaced the one that asked for it
    assign ret_ok = rd_data_val && (ret_tag == seq_tag) && !rd_cmd.set;

    always_comb begin
        mem_req.req  = ((state == RD_BIAS) || (state == RD_KER)) && !inflight;
        mem_req.we   = 1'b0;
        mem_req.addr = (state == RD_BIAS) ? reg_start : fetch_addr;
        mem_req.data = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= RD_IDLE;
            reg_start  <= '0;
            reg_last   <= '0;
            fetch_addr <= '0;
            inflight   <= 1'b0;
            seq_tag    <= 1'b0;
            ret_tag    <= 1'b0;
        end else begin
            if (rd_cmd.set) begin
                state      <= RD_BIAS;
                reg_start  <= rd_cmd.start;
                reg_last   <= rd_cmd.last;
                fetch_addr <= rd_cmd.start + 1'b1;
                inflight   <= 1'b0;
                seq_tag    <= !seq_tag;
            end else begin
                case (state)
                    RD_BIAS: begin
                        if (ret_ok) begin
                            inflight <= 1'b0;
                            state    <= RD_KER;
                        end
                    end
                    RD_KER: begin
                        if (ret_ok) begin
                            inflight <= 1'b0;
                            state    <= RD_HOLD;
                            // kernels run from start+1 to end, then start over
                            if (fetch_addr == reg_last) begin
                                fetch_addr <= reg_start + 1'b1;
                            end else begin
                                fetch_addr <= fetch_addr + 1'b1;
                            end
                        end
                    end
                    RD_HOLD: begin
                        if (kernel_rdy) begin
                            state <= RD_KER;
                        end
                    end
                    default: begin
                        state <= RD_IDLE;
                    end
                endcase
            end

            // the tag sampled here is compared on the return cycle
            if (grant) begin
                ret_tag <= seq_tag;
                // a grant on the restart edge served the old region
                if (!rd_cmd.set) begin
                    inflight <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ret_ok && (state == RD_BIAS)) begin
            bias_bus <= rd_data;
        end
        if (ret_ok && (state == RD_KER)) begin
            kernel_bus <= rd_data;
        end
    end

    a_kernel_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        (kernel_val && !kernel_rdy) |=> $stable(kernel_bus)
    ) else $error("kernel_bus changed while stalled");

endmodule

// File: verilog/ker_mem_arbiter.sv
`timescale 1ns/1ps

module ker_mem_arbiter import kernel_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_req_t            wr_req,
    input  mem_req_t            rd_req,
    output logic                wr_grant,
    output logic                rd_grant,
    output logic [KER_WORD-1:0] rd_data,
    output logic                rd_data_val
);

    logic [KER_WORD-1:0] mem [MEM_DEPTH];
    logic                last_rd;
    logic                any_grant;
    mem_req_t            sel_req;

    // on contention the side that lost last time wins
    always_comb begin
        wr_grant = 1'b0;
        rd_grant = 1'b0;
        if (wr_req.req && rd_req.req) begin
            if (last_rd) begin
                wr_grant = 1'b1;
            end else begin
                rd_grant = 1'b1;
            end
        end else begin
            wr_grant = wr_req.req;
            rd_grant = rd_req.req;
        end
    end

    assign any_grant = wr_grant || rd_grant;
    assign sel_req   = wr_grant ? wr_req : rd_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_rd     <= 1'b1;
            rd_data_val <= 1'b0;
        end else begin
            rd_data_val <= any_grant && !sel_req.we;
            if (rd_grant) begin
                last_rd <= 1'b1;
            end else if (wr_grant) begin
                last_rd <= 1'b0;
            end
        end
    end

    // single port, one address per cycle
    always_ff @(posedge clk) begin
        if (any_grant && sel_req.we) begin
            mem[sel_req.addr] <= sel_req.data;
        end else if (any_grant) begin
            rd_data <= mem[sel_req.addr];
        end
    end

    a_one_grant : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr_grant && rd_grant)
    ) else $error("writer and reader granted together");

endmodule

// File: verilog/kernel.sv
`timescale 1ns/1ps

module kernel import kernel_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [CFG_DWIDTH-1:0] cfg_data,
    input  cfg_addr_e             cfg_addr,
    input  logic                  cfg_valid,
    input  logic [STR_WIDTH-1:0]  str_ker_bus,
    input  logic                  str_ker_val,
    output logic                  str_ker_rdy,
    output logic [KER_WORD-1:0]   bias_bus,
    output logic [KER_WORD-1:0]   kernel_bus,
    output logic                  kernel_val,
    input  logic                  kernel_rdy,
    output logic                  ker_loaded
);

    region_cmd_t         wr_cmd;
    region_cmd_t         rd_cmd;
    logic [KER_WORD-1:0] word;
    logic                word_val;
    logic                word_rdy;
    mem_req_t            wr_req;
    mem_req_t            rd_req;
    logic                wr_grant;
    logic                rd_grant;
    logic [KER_WORD-1:0] rd_data;
    logic                rd_data_val;

    kernel_cfg i_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_data  (cfg_data),
        .cfg_addr  (cfg_addr),
        .cfg_valid (cfg_valid),
        .wr_cmd    (wr_cmd),
        .rd_cmd    (rd_cmd)
    );

    ker_gearbox i_gearbox (
        .clk     (clk),
        .rst_n   (rst_n),
        .up_data (str_ker_bus),
        .up_val  (str_ker_val),
        .up_rdy  (str_ker_rdy),
        .dn_data (word),
        .dn_val  (word_val),
        .dn_rdy  (word_rdy)
    );

    ker_writer i_writer (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_cmd   (wr_cmd),
        .word     (word),
        .word_val (word_val),
        .word_rdy (word_rdy),
        .grant    (wr_grant),
        .mem_req  (wr_req),
        .loaded   (ker_loaded)
    );

    ker_reader i_reader (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_cmd      (rd_cmd),
        .grant       (rd_grant),
        .rd_data     (rd_data),
        .rd_data_val (rd_data_val),
        .kernel_rdy  (kernel_rdy),
        .mem_req     (rd_req),
        .bias_bus    (bias_bus),
        .kernel_bus  (kernel_bus),
        .kernel_val  (kernel_val)
    );

    ker_mem_arbiter i_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_req      (wr_req),
        .rd_req      (rd_req),
        .wr_grant    (wr_grant),
        .rd_grant    (rd_grant),
        .rd_data     (rd_data),
        .rd_data_val (rd_data_val)
    );

endmodule

// File: verif/kernel_tb.sv
`timescale 1ns/1ps

module kernel_tb import kernel_pkg::*; ();

    localparam int ROW_NB = 4;
    localparam int LIMIT  = 200 * ROW_NB + 100;

    // one stimulus row with a second read region that is used when rd2_end is not 0
    typedef struct packed {
        logic [3:0] wr_end;
        logic [3:0] rd_start;
        logic [3:0] rd_end;
        logic [5:0] pops;
        logic       alt;
        logic [3:0] rd2_start;
        logic [3:0] rd2_end;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic [CFG_DWIDTH-1:0] cfg_data;
    cfg_addr_e             cfg_addr;
    logic                  cfg_valid;
    logic [STR_WIDTH-1:0]  str_ker_bus;
    logic                  str_ker_val;
    logic                  str_ker_rdy;
    logic [KER_WORD-1:0]   bias_bus;
    logic [KER_WORD-1:0]   kernel_bus;
    logic                  kernel_val;
    logic                  kernel_rdy;
    logic                  ker_loaded;

    row_t                 rows [ROW_NB];
    logic [STR_WIDTH-1:0] beats [$];
    int                   row_base;
    int                   pending;
    int                   seed;
    int                   cycles;
    int                   checks;
    int                   errors;

    kernel i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_data    (cfg_data),
        .cfg_addr    (cfg_addr),
        .cfg_valid   (cfg_valid),
        .str_ker_bus (str_ker_bus),
        .str_ker_val (str_ker_val),
        .str_ker_rdy (str_ker_rdy),
        .bias_bus    (bias_bus),
        .kernel_bus  (kernel_bus),
        .kernel_val  (kernel_val),
        .kernel_rdy  (kernel_rdy),
        .ker_loaded  (ker_loaded)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("checks: %0d, errors: %0d", checks, errors + 1);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic row_t make_row(input int we, input int rs, input int re, input int pops,
                                      input bit alt, input int rs2, input int re2);
        row_t r;
        r.wr_end    = we;
        r.rd_start  = rs;
        r.rd_end    = re;
        r.pops      = pops;
        r.alt       = alt;
        r.rd2_start = rs2;
        r.rd2_end   = re2;
        return r;
    endfunction

    // word a of the current region, built from beats 4a to 4a+3 with lane 0 lowest
    function automatic logic [KER_WORD-1:0] model_word(input int a);
        logic [KER_WORD-1:0] w;
        w = '0;
        for (int l = 0; l < LANE_NB; l++) begin
            w[l*KER_WIDTH +: KER_WIDTH] = beats[row_base + a*BEAT_NB + l];
        end
        return w;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic write_cfg(input cfg_addr_e addr, input logic [CFG_DWIDTH-1:0] data);
        cfg_addr  = addr;
        cfg_data  = data;
        cfg_valid = 1'b1;
        tick();
        cfg_valid = 1'b0;
        // the command strobe reaches the writer and reader on this edge
        tick();
    endtask

    task automatic send_beats(input int n, input bit loaded_low);
        int  sent;
        bit  take;
        sent        = 0;
        str_ker_val = 1'b0;
        while (sent < n) begin
            if (!str_ker_val && (($random(seed) & 3) != 0)) begin
                str_ker_val = 1'b1;
                str_ker_bus = $random(seed);
            end
            @(negedge clk);
            take = str_ker_val && str_ker_rdy;
            if (take) begin
                beats.push_back(str_ker_bus);
                sent++;
                if (loaded_low) begin
                    checks++;
                    assert (!ker_loaded) else begin
                        $display("mismatch at %0t: ker_loaded high before the last write",
                                 $time);
                        errors++;
                    end
                end
            end
            tick();
            if (take) begin
                str_ker_val = 1'b0;
            end
        end
        str_ker_val = 1'b0;
    endtask

    // fill the gearbox with the next region's first word, then expect back-pressure
    task automatic offer_extra();
        send_beats(BEAT_NB, 1'b0);
        str_ker_val = 1'b1;
        str_ker_bus = $random(seed);
        repeat (8) begin
            @(negedge clk);
            checks++;
            assert (!str_ker_rdy) else begin
                $display("mismatch at %0t: str_ker_rdy high with a full word held", $time);
                errors++;
            end
            tick();
        end
        str_ker_val = 1'b0;
        pending     = BEAT_NB;
    endtask

    task automatic collect(input int start, input int last, input int pops, input bit alt);
        int                  got;
        int                  addr;
        bit                  hold;
        logic [KER_WORD-1:0] held;
        got        = 0;
        addr       = start + 1;
        hold       = 1'b0;
        held       = '0;
        kernel_rdy = 1'b1;
        while (got < pops) begin
            @(negedge clk);
            if (hold) begin
                checks++;
                assert (kernel_val && (kernel_bus == held)) else begin
                    $display("mismatch at %0t: kernel %h changed to %h while stalled",
                             $time, held, kernel_bus);
                    errors++;
                end
            end
            if (kernel_val) begin
                checks++;
                assert (bias_bus == model_word(start)) else begin
                    $display("mismatch at %0t: bias %h, expected %h",
                             $time, bias_bus, model_word(start));
                    errors++;
                end
            end
            hold = kernel_val && !kernel_rdy;
            held = kernel_bus;
            if (kernel_val && kernel_rdy) begin
                checks++;
                assert (kernel_bus == model_word(addr)) else begin
                    $display("mismatch at %0t: kernel %h at address %0d, expected %h",
                             $time, kernel_bus, addr, model_word(addr));
                    errors++;
                end
                got++;
                addr = (addr == last) ? start + 1 : addr + 1;
            end
            tick();
            if (alt) begin
                kernel_rdy = !kernel_rdy;
            end
        end
        kernel_rdy = 1'b0;
        // park the reader on a presented kernel
        do @(negedge clk); while (!kernel_val);
        tick();
    endtask

    task automatic read_region(input int start, input int last, input int pops, input bit alt);
        // popping the parked kernel with the command puts an old fetch in flight
        // on the edge where the new region starts
        kernel_rdy = 1'b1;
        write_cfg(CFG_KER_RD, (32'(last) << (CFG_DWIDTH/2)) | 32'(start));
        collect(start, last, pops, alt);
    endtask

    initial begin
        row_t cur;
        clk         = 1'b0;
        rst_n       = 1'b0;
        cfg_data    = '0;
        cfg_addr    = CFG_KER_WR;
        cfg_valid   = 1'b0;
        str_ker_bus = '0;
        str_ker_val = 1'b0;
        kernel_rdy  = 1'b0;
        seed        = 93;
        cycles      = 0;
        checks      = 0;
        errors      = 0;
        pending     = 0;
        row_base    = 0;

        rows[0] = make_row(1, 0, 1, 5, 1'b0, 0, 0);
        rows[1] = make_row(15, 0, 9, 12, 1'b1, 10, 15);
        rows[2] = make_row(7, 3, 6, 6, 1'b1, 0, 2);
        rows[3] = make_row(4, 0, 4, 7, 1'b0, 0, 0);

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        tick();

        for (int r = 0; r < ROW_NB; r++) begin
            cur      = rows[r];
            row_base = beats.size() - pending;
            write_cfg(CFG_KER_WR, 32'(cur.wr_end));
            send_beats((cur.wr_end + 1) * BEAT_NB - pending, 1'b1);
            pending = 0;
            do @(negedge clk); while (!ker_loaded);
            tick();
            offer_extra();
            read_region(cur.rd_start, cur.rd_end, cur.pops, cur.alt);
            if (cur.rd2_end != 0) begin
                read_region(cur.rd2_start, cur.rd2_end, cur.pops, cur.alt);
            end
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
verilog/kernel_pkg.sv
verilog/kernel_cfg.sv
verilog/ker_gearbox.sv
verilog/ker_writer.sv
verilog/ker_reader.sv
verilog/ker_mem_arbiter.sv
verilog/kernel.sv
verif/kernel_tb.sv
